// File: sources.f
mem_pkg.sv
store_aligner.sv
mem_byte_lane.sv
load_extractor.sv
cp0.sv
mem_stage.sv
mem_stage_sva.sv
mem_stage_checker.sv
mem_stage_tb.sv

// File: Makefile
SOURCES := $(shell cat sources.f)

.PHONY: run clean

obj_dir/Vmem_stage_tb: $(SOURCES) sources.f
	verilator --binary --timing --assert --top-module mem_stage_tb -f sources.f -o Vmem_stage_tb

run: obj_dir/Vmem_stage_tb
	./obj_dir/Vmem_stage_tb | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb;
    logic clock = 1'b0;
    logic reset;
    logic [63:0] ex_out, ex_b_data, ex_slt_out, next_pc, d_rdata;
    logic [4:0] ex_w_regnum;
    mem_pkg::access_e ex_load_type, ex_store_type;
    logic ex_load_signed, ex_write_enable, ex_mtc0, ex_mfc0, ex_eret, ex_lui;
    logic ex_overflow, ex_reserved_inst, d_valid, d_ready;
    logic [7:0] interrupt_sources;
    logic [63:0] mem_w_data, mem_epc;
    logic [4:0] mem_w_regnum;
    logic mem_write_enable, mem_taken_handler;
    int errors, checks, tests, failed_tests;
    logic [31:0] lfsr = 32'h7a05;

    mem_stage uut (.*);
    mem_stage_checker scoreboard (.*);

    always #50 clock = ~clock;

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha3000000) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic set_idle();
        {ex_out, ex_b_data, ex_slt_out, next_pc, d_rdata} = '0;
        ex_w_regnum = '0;
        ex_load_type = mem_pkg::ACC_NONE;
        ex_store_type = mem_pkg::ACC_NONE;
        {ex_load_signed, ex_write_enable, ex_mtc0, ex_mfc0, ex_eret, ex_lui} = '0;
        {ex_overflow, ex_reserved_inst, d_valid, d_ready} = '0;
        interrupt_sources = '0;
    endtask

    // Hold the current inputs for one cycle, then return to idle
    task automatic next_cycle();
        @(posedge clock);
        #5;
        set_idle();
    endtask

    task automatic cp0_move(input logic to_cp0, input logic [4:0] regnum, input logic [63:0] v);
        ex_mtc0 = to_cp0;
        ex_mfc0 = !to_cp0;
        ex_w_regnum = regnum;
        ex_b_data = v;
        next_cycle();
    endtask

    task automatic end_test(input string name, input int errors_before);
        int target;
        int waited;
        target = checks + 2;
        waited = 0;
        while (checks < target && waited < 20) begin
            @(posedge clock);
            waited++;
        end
        if (checks < target) begin
            $display("checker stopped comparing during test %s", name);
            $display("Errors found");
            $finish;
        end
        #5;
        tests++;
        if (errors != errors_before) failed_tests++;
        $display("test %s %s", name, (errors == errors_before) ? "ok" : "FAILED");
    endtask

    initial begin
        int e;
        logic [63:0] addr;
        tests = 0;
        failed_tests = 0;
        set_idle();
        reset = 1'b1;
        repeat (2) @(posedge clock);
        #5;
        reset = 1'b0;

        e = errors;
        for (int k = 0; k < 8; k++) begin
            addr = rand_bits(32);
            ex_out = addr;
            ex_b_data = rand_bits(64);
            ex_store_type = mem_pkg::access_e'((k % 3) + 1);
            next_cycle();
            for (int t = 1; t < 4; t++) begin
                for (int s = 0; s < 2; s++) begin
                    ex_out = addr;
                    ex_load_type = mem_pkg::access_e'(t);
                    ex_load_signed = s[0];
                    next_cycle();
                end
            end
        end
        end_test("load_store", e);

        e = errors;
        ex_slt_out = 64'd1;
        ex_w_regnum = 5'(rand_bits(5));
        ex_write_enable = 1'b1;
        next_cycle();
        ex_out = rand_bits(64);
        ex_lui = 1'b1;
        ex_w_regnum = 5'd31;
        next_cycle();
        end_test("pass_through", e);

        e = errors;
        ex_out = 64'h40;
        ex_b_data = rand_bits(64);
        ex_store_type = mem_pkg::ACC_DWORD;
        d_valid = 1'b1;
        next_cycle();
        ex_out = 64'h40;
        ex_load_type = mem_pkg::ACC_DWORD;
        next_cycle();
        ex_load_type = mem_pkg::ACC_WORD;
        d_valid = 1'b1;
        d_ready = 1'b1;
        d_rdata = rand_bits(64);
        next_cycle();
        end_test("external", e);

        e = errors;
        cp0_move(1'b1, mem_pkg::CP0_STATUS, 64'h0000_a500);
        cp0_move(1'b0, mem_pkg::CP0_STATUS, 64'h0);
        interrupt_sources = 8'h5a;
        cp0_move(1'b0, mem_pkg::CP0_CAUSE, 64'h0);
        end_test("cp0_moves", e);

        e = errors;
        cp0_move(1'b1, mem_pkg::CP0_STATUS, 64'h0000_ff01);
        interrupt_sources = 8'h01;
        next_pc = 64'h1000;
        next_cycle();
        interrupt_sources = 8'h02;
        next_pc = 64'h2000;
        next_cycle();
        ex_eret = 1'b1;
        next_cycle();
        interrupt_sources = 8'h04;
        next_pc = 64'h3000;
        next_cycle();
        end_test("interrupt", e);

        e = errors;
        cp0_move(1'b1, mem_pkg::CP0_STATUS, 64'h0);
        ex_overflow = 1'b1;
        next_pc = 64'h4000;
        next_cycle();
        cp0_move(1'b0, mem_pkg::CP0_CAUSE, 64'h0);
        ex_reserved_inst = 1'b1;
        next_pc = 64'h5000;
        next_cycle();
        cp0_move(1'b0, mem_pkg::CP0_CAUSE, 64'h0);
        end_test("exceptions", e);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: mem_stage_checker.sv
`timescale 1ns/1ps

module mem_stage_checker (
    input  logic                     clock,
    input  logic                     reset,
    input  logic [63:0]              ex_out,
    input  logic [63:0]              ex_b_data,
    input  logic [63:0]              ex_slt_out,
    input  logic [4:0]               ex_w_regnum,
    input  mem_pkg::access_e         ex_load_type,
    input  mem_pkg::access_e         ex_store_type,
    input  logic                     ex_load_signed,
    input  logic                     ex_write_enable,
    input  logic                     ex_mtc0,
    input  logic                     ex_mfc0,
    input  logic                     ex_eret,
    input  logic                     ex_lui,
    input  logic                     ex_overflow,
    input  logic                     ex_reserved_inst,
    input  logic [63:0]              next_pc,
    input  logic [7:0]               interrupt_sources,
    input  logic                     d_valid,
    input  logic                     d_ready,
    input  logic [63:0]              d_rdata,
    input  logic [63:0]              mem_w_data,
    input  logic [4:0]               mem_w_regnum,
    input  logic                     mem_write_enable,
    input  logic [63:0]              mem_epc,
    input  logic                     mem_taken_handler,
    output int                       errors,
    output int                       checks
);
    // Byte-addressed model of the 2 KiB local memory
    logic [7:0] model [2048];
    logic [63:0] status_m;
    logic [63:0] epc_m;
    logic [4:0] code_m;
    logic [63:0] exp_data;
    logic [63:0] exp_epc;
    logic [4:0] exp_regnum;
    logic exp_we;
    logic exp_taken;

    function automatic int size_bytes(input mem_pkg::access_e t);
        case (t)
            mem_pkg::ACC_BYTE: return 1;
            mem_pkg::ACC_WORD: return 4;
            default: return 8;
        endcase
    endfunction

    function automatic logic [63:0] load_ref(input logic [10:0] a, input mem_pkg::access_e t,
                                             input logic s);
        logic [63:0] v;
        logic [10:0] base;
        int n;
        n = size_bytes(t);
        base = a & ~11'(n - 1);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = model[base + 11'(i)];
        end
        if (s && n < 8 && v[8*n-1]) begin
            for (int i = n; i < 8; i++) begin
                v[8*i +: 8] = 8'hff;
            end
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    initial begin
        errors = 0;
        checks = 0;
    end

    // Inputs are stable at the falling edge, as are the outputs of the last rising edge
    always @(negedge clock) begin
        logic taken;
        logic [63:0] rd;
        logic [10:0] base;
        int n;
        if (reset) begin
            for (int i = 0; i < 2048; i++) begin
                model[i] = 8'h00;
            end
            status_m = '0;
            epc_m = '0;
            code_m = 5'd0;
            exp_data = '0;
            exp_epc = '0;
            exp_regnum = '0;
            exp_we = 1'b0;
            exp_taken = 1'b0;
        end else begin
            check_value("mem_w_data", exp_data, mem_w_data);
            check_value("mem_w_regnum", 64'(exp_regnum), 64'(mem_w_regnum));
            check_value("mem_write_enable", 64'(exp_we), 64'(mem_write_enable));
            check_value("mem_epc", exp_epc, mem_epc);
            check_value("mem_taken_handler", 64'(exp_taken), 64'(mem_taken_handler));
            checks++;

            taken = ex_overflow || ex_reserved_inst || ((|(interrupt_sources & status_m[15:8]))
                    && status_m[0] && !status_m[1]);
            rd = '0;
            if (ex_w_regnum == 5'd12) rd = status_m;
            if (ex_w_regnum == 5'd13) rd = {48'b0, interrupt_sources, 1'b0, code_m, 2'b00};
            if (ex_w_regnum == 5'd14) rd = epc_m;

            if (ex_lui) exp_data = ex_out;
            else if (ex_mfc0) exp_data = rd;
            else if (d_valid && d_ready) exp_data = d_rdata;
            else if (ex_load_type != mem_pkg::ACC_NONE)
                exp_data = load_ref(ex_out[10:0], ex_load_type, ex_load_signed);
            else exp_data = ex_slt_out;
            exp_regnum = ex_w_regnum;
            exp_we = ex_write_enable;
            exp_taken = taken;

            // State updates land at the coming rising edge
            if (taken) begin
                epc_m = next_pc;
                status_m[1] = 1'b1;
                code_m = ex_overflow ? 5'd12 : ex_reserved_inst ? 5'd10 : 5'd0;
            end else begin
                if (ex_mtc0 && ex_w_regnum == 5'd14) epc_m = ex_b_data;
                if (ex_mtc0 && ex_w_regnum == 5'd12) status_m = ex_b_data;
                if (ex_mtc0 && ex_w_regnum == 5'd13) code_m = ex_b_data[6:2];
                if (ex_eret) status_m[1] = 1'b0;
            end
            exp_epc = epc_m;

            if (!d_valid && ex_store_type != mem_pkg::ACC_NONE) begin
                n = size_bytes(ex_store_type);
                base = ex_out[10:0] & ~11'(n - 1);
                for (int i = 0; i < n; i++) begin
                    model[base + 11'(i)] = ex_b_data[8*i +: 8];
                end
            end
        end
    end

endmodule

// File: mem_stage_sva.sv
`timescale 1ns/1ps

module mem_stage_sva (
    input logic        clock,
    input logic        reset,
    input logic [4:0]  ex_w_regnum,
    input logic        ex_write_enable,
    input logic        ex_overflow,
    input logic        ex_reserved_inst,
    input logic [7:0]  interrupt_sources,
    input logic [63:0] mem_w_data,
    input logic [4:0]  mem_w_regnum,
    input logic        mem_write_enable,
    input logic [63:0] mem_epc,
    input logic        mem_taken_handler
);
    a_reset_clear: assert property (@(posedge clock) $fell(reset) |->
        (mem_w_data == '0 && mem_w_regnum == '0 && !mem_write_enable
         && mem_epc == '0 && !mem_taken_handler))
        else $error("outputs not cleared after reset");

    a_pass_through: assert property (@(posedge clock) disable iff (reset)
        !$past(reset) |-> (mem_w_regnum == $past(ex_w_regnum)
                           && mem_write_enable == $past(ex_write_enable)))
        else $error("register number or write enable not passed through");

    a_taken_cause: assert property (@(posedge clock) disable iff (reset)
        mem_taken_handler |-> $past(ex_overflow || ex_reserved_inst || (|interrupt_sources)))
        else $error("handler taken without a cause");

endmodule

bind mem_stage mem_stage_sva sva (.*);

// File: mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                     clock,
    input  logic                     reset,
    input  logic [mem_pkg::XLEN-1:0] ex_out,
    input  logic [mem_pkg::XLEN-1:0] ex_b_data,
    input  logic [mem_pkg::XLEN-1:0] ex_slt_out,
    input  logic [4:0]               ex_w_regnum,
    input  mem_pkg::access_e         ex_load_type,
    input  mem_pkg::access_e         ex_store_type,
    input  logic                     ex_load_signed,
    input  logic                     ex_write_enable,
    input  logic                     ex_mtc0,
    input  logic                     ex_mfc0,
    input  logic                     ex_eret,
    input  logic                     ex_lui,
    input  logic                     ex_overflow,
    input  logic                     ex_reserved_inst,
    input  logic [mem_pkg::XLEN-1:0] next_pc,
    input  logic [7:0]               interrupt_sources,
    input  logic                     d_valid,
    input  logic                     d_ready,
    input  logic [mem_pkg::XLEN-1:0] d_rdata,
    output logic [mem_pkg::XLEN-1:0] mem_w_data,
    output logic [4:0]               mem_w_regnum,
    output logic                     mem_write_enable,
    output logic [mem_pkg::XLEN-1:0] mem_epc,
    output logic                     mem_taken_handler
);
    logic [mem_pkg::INDEX_BITS-1:0] index;
    logic [mem_pkg::LANES-1:0] lane_we;
    logic [mem_pkg::XLEN-1:0] lane_wdata;
    logic [mem_pkg::XLEN-1:0] lane_rdata;
    logic [mem_pkg::XLEN-1:0] load_data;
    logic [mem_pkg::XLEN-1:0] cp0_rdata;
    logic [mem_pkg::XLEN-1:0] cp0_epc;
    logic [mem_pkg::XLEN-1:0] w_data;
    logic taken_handler;

    // ##################################################################
    // Local data memory
    // ##################################################################

    assign index = ex_out[mem_pkg::INDEX_BITS + 2:3];

    store_aligner aligner (
        .ex_out        (ex_out),
        .ex_b_data     (ex_b_data),
        .ex_store_type (ex_store_type),
        .d_valid       (d_valid),
        .lane_we       (lane_we),
        .lane_wdata    (lane_wdata)
    );

    for (genvar i = 0; i < mem_pkg::LANES; i++) begin : g_lane
        mem_byte_lane lane (
            .clock (clock),
            .reset (reset),
            .index (index),
            .we    (lane_we[i]),
            .wdata (lane_wdata[8*i +: 8]),
            .rdata (lane_rdata[8*i +: 8])
        );
    end

    load_extractor extractor (
        .lane_rdata  (lane_rdata),
        .offset      (ex_out[2:0]),
        .load_type   (ex_load_type),
        .load_signed (ex_load_signed),
        .load_data   (load_data)
    );

    // ##################################################################
    // Coprocessor 0 and write-back
    // ##################################################################

    cp0 cp (
        .clock             (clock),
        .reset             (reset),
        .regnum            (ex_w_regnum),
        .wdata             (ex_b_data),
        .mtc0              (ex_mtc0),
        .eret              (ex_eret),
        .mfc0              (ex_mfc0),
        .overflow          (ex_overflow),
        .reserved_inst     (ex_reserved_inst),
        .next_pc           (next_pc),
        .interrupt_sources (interrupt_sources),
        .rdata             (cp0_rdata),
        .epc               (cp0_epc),
        .taken_handler     (taken_handler)
    );

    always_comb begin
        if (ex_lui) begin
            w_data = ex_out;
        end else if (ex_mfc0) begin
            w_data = cp0_rdata;
        end else if (d_valid && d_ready) begin
            w_data = d_rdata;
        end else if (ex_load_type != mem_pkg::ACC_NONE) begin
            w_data = load_data;
        end else begin
            w_data = ex_slt_out;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            mem_w_data <= '0;
            mem_w_regnum <= '0;
            mem_write_enable <= 1'b0;
            mem_epc <= '0;
            mem_taken_handler <= 1'b0;
        end else begin
            mem_w_data <= w_data;
            mem_w_regnum <= ex_w_regnum;
            mem_write_enable <= ex_write_enable;
            mem_epc <= cp0_epc;
            mem_taken_handler <= taken_handler;
        end
    end

endmodule

// File: cp0.sv
`timescale 1ns/1ps

module cp0 (
    input  logic                     clock,
    input  logic                     reset,
    input  logic [4:0]               regnum,
    input  logic [mem_pkg::XLEN-1:0] wdata,
    input  logic                     mtc0,
    input  logic                     eret,
    input  logic                     mfc0,
    input  logic                     overflow,
    input  logic                     reserved_inst,
    input  logic [mem_pkg::XLEN-1:0] next_pc,
    input  logic [7:0]               interrupt_sources,
    output logic [mem_pkg::XLEN-1:0] rdata,
    output logic [mem_pkg::XLEN-1:0] epc,
    output logic                     taken_handler
);
    logic [mem_pkg::XLEN-1:0] status;
    logic [mem_pkg::XLEN-1:0] epc_q;
    logic [mem_pkg::XLEN-1:0] epc_d;
    logic [mem_pkg::XLEN-1:0] cause_view;
    mem_pkg::exc_code_e exc_code;
    mem_pkg::exc_code_e code_d;
    logic [7:0] pending;
    logic interrupt_taken;

    // ##################################################################
    // Event detection
    // ##################################################################

    assign pending = interrupt_sources & status[mem_pkg::STATUS_IM_LO +: 8];

    assign interrupt_taken = (|pending) && status[mem_pkg::STATUS_IE]
                             && !status[mem_pkg::STATUS_EXL];

    // Exceptions ignore IE and EXL
    assign taken_handler = overflow || reserved_inst || interrupt_taken;

    always_comb begin
        if (overflow) begin
            code_d = mem_pkg::EXC_OV;
        end else if (reserved_inst) begin
            code_d = mem_pkg::EXC_RI;
        end else begin
            code_d = mem_pkg::EXC_INT;
        end
    end

    // ##################################################################
    // Registers
    // ##################################################################

    always_comb begin
        epc_d = epc_q;
        if (taken_handler) begin
            epc_d = next_pc;
        end else if (mtc0 && regnum == mem_pkg::CP0_EPC) begin
            epc_d = wdata;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            epc_q <= '0;
        end else begin
            epc_q <= epc_d;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            status <= '0;
            exc_code <= mem_pkg::EXC_INT;
        end else if (taken_handler) begin
            status[mem_pkg::STATUS_EXL] <= 1'b1;
            exc_code <= code_d;
        end else begin
            if (mtc0 && regnum == mem_pkg::CP0_STATUS) begin
                status <= wdata;
            end
            if (mtc0 && regnum == mem_pkg::CP0_CAUSE) begin
                exc_code <= mem_pkg::exc_code_e'(wdata[6:2]);
            end
            if (eret) begin
                status[mem_pkg::STATUS_EXL] <= 1'b0;
            end
        end
    end

    // Value EPC holds after the coming edge
    assign epc = epc_d;

    // Pending lines are live in IP, ExcCode sits in bits 6:2
    assign cause_view = {{(mem_pkg::XLEN - 16){1'b0}}, interrupt_sources,
                         1'b0, exc_code, 2'b00};

    always_comb begin
        rdata = '0;
        if (mfc0) begin
            case (regnum)
                mem_pkg::CP0_STATUS: rdata = status;
                mem_pkg::CP0_CAUSE:  rdata = cause_view;
                mem_pkg::CP0_EPC:    rdata = epc_q;
                default:             rdata = '0;
            endcase
        end
    end

endmodule

// File: load_extractor.sv
`timescale 1ns/1ps

module load_extractor (
    input  logic [mem_pkg::XLEN-1:0] lane_rdata,
    input  logic [2:0]               offset,
    input  mem_pkg::access_e         load_type,
    input  logic                     load_signed,
    output logic [mem_pkg::XLEN-1:0] load_data
);
    logic [7:0] byte_sel;
    logic [31:0] word_sel;
    logic [mem_pkg::XLEN-1:0] byte_ext;
    logic [mem_pkg::XLEN-1:0] word_ext;

    // Byte lane picked by the low address bits
    assign byte_sel = lane_rdata[{offset, 3'b000} +: 8];

    // Upper word when the address ends in 4
    assign word_sel = offset[2] ? lane_rdata[63:32] : lane_rdata[31:0];

    assign byte_ext = load_signed ? {{56{byte_sel[7]}}, byte_sel}
                                  : {56'b0, byte_sel};

    assign word_ext = load_signed ? {{32{word_sel[31]}}, word_sel}
                                  : {32'b0, word_sel};

    always_comb begin
        case (load_type)
            mem_pkg::ACC_BYTE: begin
                load_data = byte_ext;
            end
            mem_pkg::ACC_WORD: begin
                load_data = word_ext;
            end
            mem_pkg::ACC_DWORD: begin
                load_data = lane_rdata;
            end
            default: begin
                load_data = '0;
            end
        endcase
    end

endmodule

// File: mem_byte_lane.sv
`timescale 1ns/1ps

module mem_byte_lane (
    input  logic                           clock,
    input  logic                           reset,
    input  logic [mem_pkg::INDEX_BITS-1:0] index,
    input  logic                           we,
    input  logic [7:0]                     wdata,
    output logic [7:0]                     rdata
);
    logic [7:0] bytes [mem_pkg::MEM_WORDS];

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < mem_pkg::MEM_WORDS; i++) begin
                bytes[i] <= 8'h00;
            end
        end else if (we) begin
            bytes[index] <= wdata;
        end
    end

    // Read port is asynchronous
    assign rdata = bytes[index];

endmodule

// File: store_aligner.sv
`timescale 1ns/1ps

module store_aligner (
    input  logic [mem_pkg::XLEN-1:0]  ex_out,
    input  logic [mem_pkg::XLEN-1:0]  ex_b_data,
    input  mem_pkg::access_e          ex_store_type,
    input  logic                      d_valid,
    output logic [mem_pkg::LANES-1:0] lane_we,
    output logic [mem_pkg::XLEN-1:0]  lane_wdata
);
    logic [2:0] offset;
    logic [mem_pkg::LANES-1:0] we_raw;

    assign offset = ex_out[2:0];

    always_comb begin
        we_raw = '0;
        lane_wdata = ex_b_data;
        case (ex_store_type)
            mem_pkg::ACC_BYTE: begin
                we_raw = 8'b1 << offset;
                // Low byte copied to every lane, only one lane is enabled
                lane_wdata = {mem_pkg::LANES{ex_b_data[7:0]}};
            end
            mem_pkg::ACC_WORD: begin
                we_raw = offset[2] ? 8'hf0 : 8'h0f;
                lane_wdata = {2{ex_b_data[31:0]}};
            end
            mem_pkg::ACC_DWORD: begin
                we_raw = '1;
            end
            default: begin
                we_raw = '0;
            end
        endcase
    end

    // An access claimed by the external data port never touches local memory
    assign lane_we = d_valid ? '0 : we_raw;

endmodule

// File: mem_pkg.sv
package mem_pkg;

    // ##################################################################
    // Widths and memory geometry
    // ##################################################################

    localparam int XLEN = 64;
    localparam int LANES = 8;

    // Doublewords of local data memory, indexed by address bits 10:3
    localparam int MEM_WORDS = 256;
    localparam int INDEX_BITS = 8;

    // Load and store size as decoded by the execute stage
    typedef enum logic [1:0] {
        ACC_NONE  = 2'd0,
        ACC_BYTE  = 2'd1,
        ACC_WORD  = 2'd2,
        ACC_DWORD = 2'd3
    } access_e;

    // ##################################################################
    // Coprocessor 0
    // ##################################################################

    localparam logic [4:0] CP0_STATUS = 5'd12;
    localparam logic [4:0] CP0_CAUSE = 5'd13;
    localparam logic [4:0] CP0_EPC = 5'd14;

    // Cause register exception codes
    typedef enum logic [4:0] {
        EXC_INT = 5'd0,
        EXC_RI  = 5'd10,
        EXC_OV  = 5'd12
    } exc_code_e;

    // Status register fields, interrupt mask occupies 8 bits from IM_LO
    localparam int STATUS_IE = 0;
    localparam int STATUS_EXL = 1;
    localparam int STATUS_IM_LO = 8;

endpackage
